/* hdl/mem_map_pkg.sv */
`default_nettype none

package mem_map_pkg;

    // Bus widths
    localparam int addr_w = 32;
    localparam int line_w = 256;               // One L1 line
    localparam int beat_w = 128;               // Two beats per line
    localparam int mmio_w = 32;

    // Top nibble of the byte address selects the MMIO space
    localparam logic [3:0] mmio_tag = 4'hF;

    // Line index is address bits 12..5, anything above aliases
    localparam int line_idx_bits = 8;
    localparam int mem_depth = 2 * (1 << line_idx_bits);    // 512 beats

    // MMIO word offsets, taken from address bits 4..2
    localparam int mmio_scratch_regs = 4;      // Offsets 0..3
    localparam int mmio_count_off = 4;         // Read-only write counter

endpackage

`default_nettype wire

/* hdl/mmu_pkg.sv */
`default_nettype none

package mmu_pkg;

    typedef enum logic [2:0] {
        st_idle,                               // Low beat / MMIO strobe goes out here
        st_high,                               // High beat address
        st_fetch,                              // Read only, waits for the high beat
        st_mmio_wait,
        st_resp                                // Done is raised, then back to idle
    } mmu_state_e;

    // Decoded opcode of the request currently held by the L1 side
    typedef enum logic [2:0] {
        req_none,
        req_mem_read,
        req_mem_write,
        req_mmio_read,
        req_mmio_write
    } req_kind_e;

endpackage

`default_nettype wire

/* hdl/line_memory.sv */
`timescale 1ns/100ps
`default_nettype none

module line_memory (
    input  wire                                 sys_clk,
    input  wire  [mem_map_pkg::line_idx_bits:0] mem_addr,
    input  wire  [mem_map_pkg::beat_w-1:0]      mem_wdata,
    input  wire                                 mem_we,
    output logic [mem_map_pkg::beat_w-1:0]      mem_rdata
);
    import mem_map_pkg::*;

    // Entry 2*line+0 holds bits 127:0 of a line, 2*line+1 bits 255:128
    logic [beat_w-1:0] mem [mem_depth];

    always_ff @(posedge sys_clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    always_ff @(posedge sys_clk) begin
        mem_rdata <= mem[mem_addr];                     // Old data on a same-cycle write
    end

endmodule

`default_nettype wire

/* hdl/mmio_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module mmio_regs (
    input  wire                            sys_clk,
    input  wire                            rst_n,
    input  wire                            mmio_read,
    input  wire                            mmio_write,
    input  wire  [mem_map_pkg::addr_w-1:0] mmio_addr,
    input  wire  [mem_map_pkg::mmio_w-1:0] mmio_wdata,
    output logic                           mmio_done,
    output logic [mem_map_pkg::mmio_w-1:0] mmio_rdata
);
    import mem_map_pkg::*;

    logic [mmio_w-1:0] scratch [mmio_scratch_regs];
    logic [mmio_w-1:0] write_count;
    logic [2:0]        word_off;
    logic [mmio_w-1:0] read_word;

    assign word_off = mmio_addr[4:2];

    always_comb begin
        if (word_off < mmio_scratch_regs) begin
            read_word = scratch[word_off[1:0]];
        end else if (word_off == mmio_count_off) begin
            read_word = write_count;
        end else begin
            read_word = '0;                             // Unmapped
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < mmio_scratch_regs; i++) begin
                scratch[i] <= '0;
            end
            write_count <= '0;
            mmio_done   <= 1'b0;
            mmio_rdata  <= '0;
        end else begin
            mmio_done  <= mmio_read || mmio_write;
            mmio_rdata <= mmio_read ? read_word : '0;
            if (mmio_write) begin
                write_count <= write_count + 1'b1;      // Counts every write, wraps
                if (word_off < mmio_scratch_regs) begin
                    scratch[word_off[1:0]] <= mmio_wdata;
                end
            end
        end
    end

    a_strobe_exclusive: assert property (@(posedge sys_clk) disable iff (!rst_n)
        !(mmio_read && mmio_write));

endmodule

`default_nettype wire

/* hdl/l1_mmu.sv */
`timescale 1ns/100ps
`default_nettype none

module l1_mmu (
    input  wire                                 sys_clk,
    input  wire                                 rst_n,
    input  wire                                 l1_mmu_req_read,
    input  wire                                 l1_mmu_req_write,
    input  wire  [mem_map_pkg::addr_w-1:0]      l1_mmu_req_addr,
    input  wire  [mem_map_pkg::line_w-1:0]      l1_mmu_write_data,
    output logic                                mmu_l1_read_done,
    output logic                                mmu_l1_write_done,
    output logic [mem_map_pkg::line_w-1:0]      mmu_l1_read_data,
    output logic [mem_map_pkg::line_idx_bits:0] mem_addr,
    output logic [mem_map_pkg::beat_w-1:0]      mem_wdata,
    output logic                                mem_we,
    input  wire  [mem_map_pkg::beat_w-1:0]      mem_rdata,
    output logic                                mmio_read,
    output logic                                mmio_write,
    output logic [mem_map_pkg::addr_w-1:0]      mmio_addr,
    output logic [mem_map_pkg::mmio_w-1:0]      mmio_wdata,
    input  wire                                 mmio_done,
    input  wire  [mem_map_pkg::mmio_w-1:0]      mmio_rdata
);
    import mem_map_pkg::*;
    import mmu_pkg::*;

    mmu_state_e        state;
    req_kind_e         kind;
    logic              is_mmio;
    logic              beat_hi;
    logic [beat_w-1:0] hold_low;

    assign is_mmio = (l1_mmu_req_addr[addr_w-1 -: $bits(mmio_tag)] == mmio_tag);

    always_comb begin
        if (l1_mmu_req_read) begin
            kind = is_mmio ? req_mmio_read : req_mem_read;
        end else if (l1_mmu_req_write) begin
            kind = is_mmio ? req_mmio_write : req_mem_write;
        end else begin
            kind = req_none;
        end
    end

    // Memory side, low beat in idle and high beat in every later state
    assign beat_hi   = (state != st_idle);
    assign mem_addr  = {l1_mmu_req_addr[line_idx_bits+4:5], beat_hi};
    assign mem_wdata = beat_hi ? l1_mmu_write_data[line_w-1:beat_w]
                               : l1_mmu_write_data[beat_w-1:0];
    assign mem_we    = (kind == req_mem_write) && (state == st_idle || state == st_high);

    // MMIO strobes last exactly the idle cycle of the request
    assign mmio_read  = (state == st_idle) && (kind == req_mmio_read);
    assign mmio_write = (state == st_idle) && (kind == req_mmio_write);
    assign mmio_addr  = {l1_mmu_req_addr[addr_w-1:2], 2'b00};
    assign mmio_wdata = l1_mmu_write_data[mmio_w-1:0];

    always_ff @(posedge sys_clk) begin
        if (state == st_high && kind == req_mem_read) begin
            hold_low <= mem_rdata;                      // Low beat, addressed in idle
        end else if (state == st_mmio_wait && mmio_done) begin
            hold_low <= {{(beat_w-mmio_w){1'b0}}, mmio_rdata};
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state             <= st_idle;
            mmu_l1_read_done  <= 1'b0;
            mmu_l1_write_done <= 1'b0;
            mmu_l1_read_data  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    case (kind)
                        req_mem_read, req_mem_write:   state <= st_high;
                        req_mmio_read, req_mmio_write: state <= st_mmio_wait;
                        default:                       state <= st_idle;
                    endcase
                end
                st_high: begin
                    if (kind == req_mem_read) begin
                        state <= st_fetch;              // High beat still in flight
                    end else begin
                        state <= st_resp;
                    end
                end
                st_fetch: begin
                    state <= st_resp;
                end
                st_mmio_wait: begin
                    if (mmio_done) begin
                        state <= st_resp;
                    end
                end
                st_resp: begin
                    if (mmu_l1_read_done || mmu_l1_write_done) begin
                        state             <= st_idle;   // Requester drops at this edge
                        mmu_l1_read_done  <= 1'b0;
                        mmu_l1_write_done <= 1'b0;
                        mmu_l1_read_data  <= '0;
                    end else if (kind == req_mem_read) begin
                        mmu_l1_read_done  <= 1'b1;
                        mmu_l1_read_data  <= {mem_rdata, hold_low};
                    end else if (kind == req_mmio_read) begin
                        mmu_l1_read_done  <= 1'b1;
                        mmu_l1_read_data  <= {{(line_w-beat_w){1'b0}}, hold_low};
                    end else begin
                        mmu_l1_write_done <= 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    a_req_exclusive: assert property (@(posedge sys_clk) disable iff (!rst_n)
        !(l1_mmu_req_read && l1_mmu_req_write));

    a_read_done_pulse: assert property (@(posedge sys_clk) disable iff (!rst_n)
        mmu_l1_read_done |=> !mmu_l1_read_done);

    a_write_done_pulse: assert property (@(posedge sys_clk) disable iff (!rst_n)
        mmu_l1_write_done |=> !mmu_l1_write_done);

    // A request left high past its done would strobe a second time
    a_strobe_once: assert property (@(posedge sys_clk) disable iff (!rst_n)
        (mmio_read || mmio_write) |-> !$past(mmu_l1_read_done || mmu_l1_write_done));

endmodule

`default_nettype wire

/* hdl/mem_subsys_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_subsys_top (
    input  wire                            sys_clk,
    input  wire                            rst_n,
    input  wire                            l1_mmu_req_read,
    input  wire                            l1_mmu_req_write,
    input  wire  [mem_map_pkg::addr_w-1:0] l1_mmu_req_addr,
    input  wire  [mem_map_pkg::line_w-1:0] l1_mmu_write_data,
    output logic                           mmu_l1_read_done,
    output logic                           mmu_l1_write_done,
    output logic [mem_map_pkg::line_w-1:0] mmu_l1_read_data
);
    import mem_map_pkg::*;

    logic [line_idx_bits:0] mem_addr;
    logic [beat_w-1:0]      mem_wdata;
    logic                   mem_we;
    logic [beat_w-1:0]      mem_rdata;

    logic                   mmio_read;
    logic                   mmio_write;
    logic [addr_w-1:0]      mmio_addr;
    logic [mmio_w-1:0]      mmio_wdata;
    logic                   mmio_done;
    logic [mmio_w-1:0]      mmio_rdata;

    l1_mmu u_l1_mmu (
        .sys_clk           (sys_clk),
        .rst_n             (rst_n),
        .l1_mmu_req_read   (l1_mmu_req_read),
        .l1_mmu_req_write  (l1_mmu_req_write),
        .l1_mmu_req_addr   (l1_mmu_req_addr),
        .l1_mmu_write_data (l1_mmu_write_data),
        .mmu_l1_read_done  (mmu_l1_read_done),
        .mmu_l1_write_done (mmu_l1_write_done),
        .mmu_l1_read_data  (mmu_l1_read_data),
        .mem_addr          (mem_addr),
        .mem_wdata         (mem_wdata),
        .mem_we            (mem_we),
        .mem_rdata         (mem_rdata),
        .mmio_read         (mmio_read),
        .mmio_write        (mmio_write),
        .mmio_addr         (mmio_addr),
        .mmio_wdata        (mmio_wdata),
        .mmio_done         (mmio_done),
        .mmio_rdata        (mmio_rdata)
    );

    line_memory u_line_memory (
        .sys_clk   (sys_clk),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_rdata (mem_rdata)
    );

    mmio_regs u_mmio_regs (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .mmio_read  (mmio_read),
        .mmio_write (mmio_write),
        .mmio_addr  (mmio_addr),
        .mmio_wdata (mmio_wdata),
        .mmio_done  (mmio_done),
        .mmio_rdata (mmio_rdata)
    );

endmodule

`default_nettype wire

/* sim/tb_mem_subsys.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsys;
    import mem_map_pkg::*;
    import mmu_pkg::*;

    localparam int timeout_cycles = 20;

    logic              sys_clk;
    logic              rst_n;
    logic              l1_mmu_req_read;
    logic              l1_mmu_req_write;
    logic [addr_w-1:0] l1_mmu_req_addr;
    logic [line_w-1:0] l1_mmu_write_data;
    logic              mmu_l1_read_done;
    logic              mmu_l1_write_done;
    logic [line_w-1:0] mmu_l1_read_data;

    logic [line_w-1:0] line_model [int];               // Keyed by aliased line index
    logic [mmio_w-1:0] scratch_model [mmio_scratch_regs];
    logic [mmio_w-1:0] count_model;
    logic [line_w-1:0] expect_q [$];
    string             name_q [$];
    int                reads_issued;
    int                writes_issued;
    int                read_dones;
    int                write_dones;
    logic              prev_read_done;
    logic              prev_write_done;

    mem_subsys_top uut (
        .sys_clk           (sys_clk),
        .rst_n             (rst_n),
        .l1_mmu_req_read   (l1_mmu_req_read),
        .l1_mmu_req_write  (l1_mmu_req_write),
        .l1_mmu_req_addr   (l1_mmu_req_addr),
        .l1_mmu_write_data (l1_mmu_write_data),
        .mmu_l1_read_done  (mmu_l1_read_done),
        .mmu_l1_write_done (mmu_l1_write_done),
        .mmu_l1_read_data  (mmu_l1_read_data)
    );

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check(input string test, input logic [line_w-1:0] expected,
                         input logic [line_w-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch %s expected %h actual %h", test, expected, actual));
        end
    endtask

    function automatic logic [line_w-1:0] ref_line(input logic [addr_w-1:0] addr);
        int idx;
        idx = int'(addr[line_idx_bits+4:5]);            // Bits above 12 alias
        if (line_model.exists(idx)) begin
            return line_model[idx];
        end
        return '0;
    endfunction

    function automatic logic [line_w-1:0] ref_mmio(input int off);
        logic [mmio_w-1:0] word;
        if (off < mmio_scratch_regs) begin
            word = scratch_model[off];
        end else if (off == mmio_count_off) begin
            word = count_model;
        end else begin
            word = '0;
        end
        return {{(line_w-mmio_w){1'b0}}, word};
    endfunction

    function automatic logic [line_w-1:0] random_line();
        logic [line_w-1:0] line;
        for (int i = 0; i < line_w / 32; i++) begin
            line[i*32 +: 32] = $urandom;
        end
        return line;
    endfunction

    // Random upper bits and byte offset, top nibble kept out of the MMIO space
    function automatic logic [addr_w-1:0] mem_address(input int idx);
        logic [addr_w-1:0] addr;
        addr = $urandom;
        addr[addr_w-1 -: 4] = 4'($urandom_range(14, 0));
        addr[line_idx_bits+4:5] = idx[line_idx_bits-1:0];
        return addr;
    endfunction

    function automatic logic [addr_w-1:0] mmio_address(input int off);
        logic [addr_w-1:0] addr;
        addr = $urandom;
        addr[addr_w-1 -: 4] = mmio_tag;
        addr[4:2] = off[2:0];
        return addr;
    endfunction

    // One request, held until its done; latency counts from the edge that first sees it
    task automatic issue(input req_kind_e kind, input logic [addr_w-1:0] addr,
                         input logic [line_w-1:0] data, input string test);
        string full;
        bit    is_read;
        int    waited;
        int    exp_lat;
        logic  got_read;
        logic  got_write;
        full    = $sformatf("%s %s", test, kind.name());
        is_read = (kind == req_mem_read) || (kind == req_mmio_read);
        exp_lat = (kind == req_mem_read) ? 3 : 2;
        if (kind == req_mem_read) begin
            expect_q.push_back(ref_line(addr));
            name_q.push_back(full);
        end else if (kind == req_mmio_read) begin
            expect_q.push_back(ref_mmio(int'(addr[4:2])));
            name_q.push_back(full);
        end
        @(posedge sys_clk);
        l1_mmu_req_read   <= is_read;
        l1_mmu_req_write  <= !is_read;
        l1_mmu_req_addr   <= addr;
        l1_mmu_write_data <= data;
        waited    = 0;
        got_read  = 1'b0;
        got_write = 1'b0;
        while (!got_read && !got_write) begin
            @(posedge sys_clk);
            waited++;
            got_read  = mmu_l1_read_done;
            got_write = mmu_l1_write_done;
            if (!got_read && !got_write && waited >= timeout_cycles) begin
                abort_run($sformatf("no done for %s within %0d cycles", full, timeout_cycles));
            end
        end
        l1_mmu_req_read  <= 1'b0;                       // Dropped at the done edge
        l1_mmu_req_write <= 1'b0;
        if (got_read != is_read) begin
            abort_run($sformatf("%s was answered by the wrong done output", full));
        end
        check({full, " latency"}, line_w'(exp_lat), line_w'(waited - 2));
        if (is_read) begin
            reads_issued++;
        end else begin
            writes_issued++;
        end
        if (kind == req_mem_write) begin
            line_model[int'(addr[line_idx_bits+4:5])] = data;
        end else if (kind == req_mmio_write) begin
            if (addr[4:2] < mmio_scratch_regs) begin
                scratch_model[addr[3:2]] = data[mmio_w-1:0];
            end
            count_model++;                              // Offset 4 writes count too
        end
    endtask

    always @(posedge sys_clk) begin
        if (!rst_n) begin
            prev_read_done  = 1'b0;
            prev_write_done = 1'b0;
        end else begin
            if (mmu_l1_read_done && prev_read_done) begin
                abort_run("read done stayed high for two cycles");
            end
            if (mmu_l1_write_done && prev_write_done) begin
                abort_run("write done stayed high for two cycles");
            end
            if (mmu_l1_read_done) begin
                read_dones++;
                if (expect_q.size() == 0) begin
                    abort_run("read done arrived with no read pending");
                end else begin
                    check(name_q.pop_front(), expect_q.pop_front(), mmu_l1_read_data);
                end
            end else begin
                check("read data outside done", '0, mmu_l1_read_data);
            end
            if (mmu_l1_write_done) begin
                write_dones++;
            end
            prev_read_done  = mmu_l1_read_done;
            prev_write_done = mmu_l1_write_done;
        end
    end

    initial begin
        logic [addr_w-1:0] addr;
        int                idx;
        void'($urandom(32'hc5c9_b862));
        rst_n             = 1'b0;
        l1_mmu_req_read   = 1'b0;
        l1_mmu_req_write  = 1'b0;
        l1_mmu_req_addr   = '0;
        l1_mmu_write_data = '0;
        reads_issued      = 0;
        writes_issued     = 0;
        read_dones        = 0;
        write_dones       = 0;
        count_model       = '0;
        for (int i = 0; i < mmio_scratch_regs; i++) begin
            scratch_model[i] = '0;
        end
        repeat (16) @(posedge sys_clk);
        rst_n <= 1'b1;
        repeat (10) begin
            @(posedge sys_clk);
            check("idle after reset", '0, {mmu_l1_read_done, mmu_l1_write_done});
        end
        addr = mem_address(3);
        issue(req_mem_write, addr, random_line(), "line write");
        issue(req_mem_read, addr, '0, "line readback");
        for (int i = 0; i < 200; i++) begin
            idx  = $urandom_range(255, 0);
            addr = mem_address(idx);
            if (!line_model.exists(idx) || $urandom_range(1, 0) == 1) begin
                issue(req_mem_write, addr, random_line(), $sformatf("random %0d", i));
            end else begin
                issue(req_mem_read, addr, '0, $sformatf("random %0d", i));
            end
        end
        for (int off = 0; off < mmio_scratch_regs; off++) begin
            issue(req_mmio_write, mmio_address(off), random_line(), $sformatf("scratch %0d", off));
        end
        for (int off = 0; off < 8; off++) begin
            issue(req_mmio_read, mmio_address(off), '0, $sformatf("offset %0d", off));
        end
        issue(req_mmio_write, mmio_address(mmio_count_off), random_line(), "counter write");
        issue(req_mmio_read, mmio_address(mmio_count_off), '0, "counter read");
        // MMIO traffic sharing the low address bits of a stored line
        addr = mem_address(9);
        issue(req_mem_write, addr, random_line(), "alias line");
        issue(req_mmio_write, {mmio_tag, addr[27:0]}, random_line(), "alias mmio");
        issue(req_mmio_read, {mmio_tag, addr[27:0]}, '0, "alias mmio");
        issue(req_mem_read, addr, '0, "alias line");
        repeat (2) @(posedge sys_clk);
        check("read done count", line_w'(reads_issued), line_w'(read_dones));
        check("write done count", line_w'(writes_issued), line_w'(write_dones));
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
hdl/mem_map_pkg.sv
hdl/mmu_pkg.sv
hdl/line_memory.sv
hdl/mmio_regs.sv
hdl/l1_mmu.sv
hdl/mem_subsys_top.sv
sim/tb_mem_subsys.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= sim passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
